// File: common/supervisor_consts.svh
`ifndef SUPERVISOR_CONSTS_SVH
`define SUPERVISOR_CONSTS_SVH

// --------------------------------------------------------------------------
// Word widths
// --------------------------------------------------------------------------

// Host pattern word
`define PAT_WIDTH 8

// Retiring program counter
`define PC_WIDTH 64

`define OP_WIDTH 4

// Core number field inside the pattern word
`define CORE_ID_WIDTH 4

// --------------------------------------------------------------------------
// Progress monitor
// --------------------------------------------------------------------------

// Equal valid PC samples that count as a hang
`define STUCK_LIMIT 500

// Wide enough to hold STUCK_LIMIT
`define STUCK_CNT_WIDTH 9

// --------------------------------------------------------------------------
// Sleep after verdict
// --------------------------------------------------------------------------

// Cycles from first verdict to core reset
`define SLEEP_DELAY 20

`define SLEEP_CNT_WIDTH 5

`endif

// File: common/supervisorPkg.sv
`include "supervisor_consts.svh"

package supervisorPkg;

  // Host opcodes, targeted ones first
  typedef enum logic [`OP_WIDTH-1:0] {
    opNone,
    opForceTileReset,
    opReleaseTileReset,
    opForceCoreReset,
    opReleaseCoreReset,
    opEnableMonitor,
    opGetCoreResetStatus,   // Status queries answer into the pattern
    opGetPassFailStatus,
    opGetProgramLoaded,
    opDisableStuckCheck
  } cmdOp_e;

  // Pattern seen as a command target
  typedef struct packed {
    logic [`PAT_WIDTH-`CORE_ID_WIDTH-1:0] pad;
    logic [`CORE_ID_WIDTH-1:0]            coreId;
  } patTarget_s;

  // Pattern seen as a pass/fail answer
  typedef struct packed {
    logic [`PAT_WIDTH-3:0] pad;
    logic                  fail;
    logic                  pass;   // Bit 0
  } patVerdict_s;

  // One register, two readings
  typedef union packed {
    patTarget_s            target;
    patVerdict_s           verdict;
    logic [`PAT_WIDTH-1:0] raw;
  } patWord_u;

endpackage

// File: logic/commandDecoder.sv
`include "supervisor_consts.svh"

// Turns host command strobes into registered one-cycle op pulses.
// The pattern target is judged here against this core's number, on the
// same edge that samples the strobe.
module commandDecoder #(
  parameter logic [`CORE_ID_WIDTH-1:0] myCoreId = '0
) (
  input  logic                    dvtFlags,
  input  logic                    pcFail,
  input  logic                    cmdValid,
  input  supervisorPkg::cmdOp_e   cmdOp,
  input  supervisorPkg::patWord_u patWord,
  output supervisorPkg::cmdOp_e   opPulse,
  output logic                    opValid,
  output logic                    targetHit,
  output logic                    stuckDisable
);

  logic idMatch;
  logic stuckCmd;

  // --------------------------------------------------------------------------
  // Target compare and stuck-check split
  // --------------------------------------------------------------------------

  assign idMatch  = (patWord.target.coreId == myCoreId);
  assign stuckCmd = cmdValid && (cmdOp == supervisorPkg::opDisableStuckCheck);

  // --------------------------------------------------------------------------
  // Op register
  // --------------------------------------------------------------------------

  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      opPulse      <= supervisorPkg::opNone;
      opValid      <= 1'b0;
      targetHit    <= 1'b0;
      stuckDisable <= 1'b0;
    end else begin
      opValid <= cmdValid;                  // One pulse per strobe
      if (cmdValid) begin
        opPulse <= cmdOp;
      end else begin
        opPulse <= supervisorPkg::opNone;   // Idle op between strobes
      end

      // Level tracks the pattern every cycle
      targetHit    <= idMatch;

      // Not targeted, acts on every core
      stuckDisable <= stuckCmd;
    end
  end

endmodule

// File: monitor/pcProgressMonitor.sv
`include "supervisor_consts.svh"

// Watches the retiring PC and latches a single pass or fail verdict.
// Samples are captured one edge, then matched and counted the next.
module pcProgressMonitor (
  input  logic                 dvtFlags,
  input  logic                 pcFail,
  input  logic [`PC_WIDTH-1:0] pcValue,
  input  logic                 pcValid,
  input  logic                 coreReset,
  input  logic [`PC_WIDTH-1:0] passAddr,
  input  logic [`PC_WIDTH-1:0] failAddr,
  input  logic [`PC_WIDTH-1:0] hangAddr,
  input  logic                 addrValid,
  input  logic                 stuckDisable,
  output logic                 testPass,
  output logic                 testFail
);

  localparam logic [`STUCK_CNT_WIDTH-1:0] stuckLimit = `STUCK_LIMIT;

  logic [`PC_WIDTH-1:0]        pcQ;
  logic [`PC_WIDTH-1:0]        lastPc;
  logic                        sampleValid;
  logic                        haveLast;
  logic                        checkerEn;
  logic [`STUCK_CNT_WIDTH-1:0] stuckCnt;
  logic [`STUCK_CNT_WIDTH-1:0] stuckCntNext;
  logic                        pcRepeat;
  logic                        stuckHit;
  logic                        passHit;
  logic                        failHit;
  logic                        decided;

  // --------------------------------------------------------------------------
  // Capture stage
  // --------------------------------------------------------------------------

  always_ff @(posedge dvtFlags) begin
    pcQ <= pcValue;
    if (sampleValid) begin
      lastPc <= pcQ;   // Previous valid PC
    end
  end

  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      sampleValid <= 1'b0;
      haveLast    <= 1'b0;
      checkerEn   <= 1'b1;
      stuckCnt    <= '0;
    end else begin
      sampleValid <= pcValid && !coreReset;   // Core asleep, PC ignored
      if (sampleValid) begin
        haveLast <= 1'b1;
      end
      if (stuckDisable) begin
        checkerEn <= 1'b0;
      end
      stuckCnt <= stuckCntNext;
    end
  end

  // --------------------------------------------------------------------------
  // Stuck counter, saturates at the limit
  // --------------------------------------------------------------------------

  assign pcRepeat = haveLast && (pcQ == lastPc);

  always_comb begin
    stuckCntNext = stuckCnt;
    if (sampleValid) begin
      if (!pcRepeat) begin
        stuckCntNext = '0;
      end else if (stuckCnt != stuckLimit) begin
        stuckCntNext = stuckCnt + 1'b1;
      end
    end
  end

  assign stuckHit = checkerEn && (stuckCntNext == stuckLimit);

  // Zero entries in the table are unused
  assign passHit = (passAddr != '0) && (pcQ == passAddr);
  assign failHit = ((failAddr != '0) && (pcQ == failAddr)) ||
                   ((hangAddr != '0) && (pcQ == hangAddr));
  assign decided = testPass || testFail;

  // --------------------------------------------------------------------------
  // Sticky verdict, first one wins
  // --------------------------------------------------------------------------

  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      testPass <= 1'b0;
      testFail <= 1'b0;
    end else if (!decided) begin
      if (stuckHit) begin
        testFail <= 1'b1;
      end else if (sampleValid) begin
        if (!addrValid) begin
          testFail <= 1'b1;   // PC running without a loaded table
        end else if (passHit) begin
          testPass <= 1'b1;
        end else if (failHit) begin
          testFail <= 1'b1;
        end
      end
    end
  end

endmodule

// File: logic/resetStatusUnit.sv
`include "supervisor_consts.svh"

// Holds the tile and core reset levels, puts the core to sleep after the
// verdict, and owns the pattern register that queries answer into.
module resetStatusUnit (
  input  logic                    dvtFlags,
  input  logic                    pcFail,
  input  supervisorPkg::cmdOp_e   opPulse,
  input  logic                    opValid,
  input  logic                    targetHit,
  input  logic                    patWrite,
  input  logic [`PAT_WIDTH-1:0]   patIn,
  input  logic                    programLoaded,
  input  logic                    testPass,
  input  logic                    testFail,
  output supervisorPkg::patWord_u patWord,
  output logic                    tileReset,
  output logic                    coreReset,
  output logic                    monitorEnable,
  output logic                    cmdDone
);

  localparam logic [`SLEEP_CNT_WIDTH-1:0] sleepLoad = `SLEEP_DELAY - 1;
  localparam logic [`SLEEP_CNT_WIDTH-1:0] sleepLast = 1;

  logic                        hit;
  logic                        verdict;
  logic                        verdictQ;
  logic                        verdictRise;
  logic                        sleepArmed;
  logic [`SLEEP_CNT_WIDTH-1:0] sleepCnt;
  logic                        sleepFire;

  assign hit         = opValid && targetHit;   // Targeted op for this core
  assign verdict     = testPass || testFail;
  assign verdictRise = verdict && !verdictQ;
  assign sleepFire   = sleepArmed && (sleepCnt == sleepLast);

  // --------------------------------------------------------------------------
  // Sleep timer
  // --------------------------------------------------------------------------

  // Loaded one edge after the verdict rises, so the core reset lands
  // SLEEP_DELAY edges after the verdict edge
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      verdictQ   <= 1'b0;
      sleepArmed <= 1'b0;
      sleepCnt   <= '0;
    end else begin
      verdictQ <= verdict;
      if (verdictRise && !coreReset) begin
        sleepArmed <= 1'b1;
        sleepCnt   <= sleepLoad;
      end else if (sleepFire) begin
        sleepArmed <= 1'b0;
      end else if (sleepArmed) begin
        sleepCnt <= sleepCnt - 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Reset and monitor levels
  // --------------------------------------------------------------------------

  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      tileReset     <= 1'b1;   // Tile held until the program is in
      coreReset     <= 1'b0;
      monitorEnable <= 1'b0;
    end else begin
      if (hit) begin
        case (opPulse)
          supervisorPkg::opForceTileReset:   tileReset     <= 1'b1;
          supervisorPkg::opReleaseTileReset: tileReset     <= 1'b0;
          supervisorPkg::opForceCoreReset:   coreReset     <= 1'b1;
          supervisorPkg::opReleaseCoreReset: coreReset     <= 1'b0;
          supervisorPkg::opEnableMonitor:    monitorEnable <= 1'b1;
          default: ;
        endcase
      end
      if (sleepFire) begin
        coreReset <= 1'b1;   // Sleep wins over a release on the same edge
      end
    end
  end

  // --------------------------------------------------------------------------
  // Pattern register and completion
  // --------------------------------------------------------------------------

  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      patWord <= '0;
      cmdDone <= 1'b0;
    end else begin
      cmdDone <= opValid;   // Every command completes, hit or not
      if (patWrite) begin
        patWord.raw <= patIn;
      end
      if (opValid) begin
        case (opPulse)
          supervisorPkg::opGetCoreResetStatus: patWord.raw[0] <= coreReset;
          supervisorPkg::opGetProgramLoaded:   patWord.raw[0] <= programLoaded;
          supervisorPkg::opGetPassFailStatus: begin
            patWord.verdict <= '{pad: '0, fail: testFail, pass: testPass};
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: logic/coreSupervisor.sv
`include "supervisor_consts.svh"

// Per-core test supervisor
module coreSupervisor #(
  parameter logic [`CORE_ID_WIDTH-1:0] myCoreId = '0
) (
  input  logic                  dvtFlags,
  input  logic                  pcFail,
  // Host side
  input  logic                  patWrite,
  input  logic [`PAT_WIDTH-1:0] patIn,
  input  logic                  cmdValid,
  input  supervisorPkg::cmdOp_e cmdOp,
  // Core side
  input  logic [`PC_WIDTH-1:0]  pcValue,
  input  logic                  pcValid,
  input  logic                  programLoaded,
  // Pass/fail address table
  input  logic [`PC_WIDTH-1:0]  passAddr,
  input  logic [`PC_WIDTH-1:0]  failAddr,
  input  logic [`PC_WIDTH-1:0]  hangAddr,
  input  logic                  addrValid,
  // Controls and status
  output logic                  tileReset,
  output logic                  coreReset,
  output logic                  monitorEnable,
  output logic                  testPass,
  output logic                  testFail,
  output logic [`PAT_WIDTH-1:0] patOut,
  output logic                  cmdDone
);

  supervisorPkg::patWord_u patWord;
  supervisorPkg::cmdOp_e   opPulse;
  logic                    opValid;
  logic                    targetHit;
  logic                    stuckDisable;

  commandDecoder #(
    .myCoreId (myCoreId)
  ) i_commandDecoder (
    .dvtFlags     (dvtFlags),
    .pcFail       (pcFail),
    .cmdValid     (cmdValid),
    .cmdOp        (cmdOp),
    .patWord      (patWord),
    .opPulse      (opPulse),
    .opValid      (opValid),
    .targetHit    (targetHit),
    .stuckDisable (stuckDisable)
  );

  pcProgressMonitor i_pcProgressMonitor (
    .dvtFlags     (dvtFlags),
    .pcFail       (pcFail),
    .pcValue      (pcValue),
    .pcValid      (pcValid),
    .coreReset    (coreReset),   // PC ignored while asleep
    .passAddr     (passAddr),
    .failAddr     (failAddr),
    .hangAddr     (hangAddr),
    .addrValid    (addrValid),
    .stuckDisable (stuckDisable),
    .testPass     (testPass),
    .testFail     (testFail)
  );

  resetStatusUnit i_resetStatusUnit (
    .dvtFlags      (dvtFlags),
    .pcFail        (pcFail),
    .opPulse       (opPulse),
    .opValid       (opValid),
    .targetHit     (targetHit),
    .patWrite      (patWrite),
    .patIn         (patIn),
    .programLoaded (programLoaded),
    .testPass      (testPass),
    .testFail      (testFail),
    .patWord       (patWord),
    .tileReset     (tileReset),
    .coreReset     (coreReset),
    .monitorEnable (monitorEnable),
    .cmdDone       (cmdDone)
  );

  assign patOut = patWord.raw;

endmodule

// File: sim/coreSupervisor_properties.sv
`include "supervisor_consts.svh"

module coreSupervisorProperties (
  input logic dvtFlags,
  input logic pcFail,
  input logic cmdValid,
  input logic cmdDone,
  input logic testPass,
  input logic testFail,
  input logic coreReset,
  input logic tileReset
);
  timeunit 1ns;
  timeprecision 100ps;

  // --------------------------------------------------------------------------
  // Command completion and verdict rules
  // --------------------------------------------------------------------------

  cmdDoneLatency: assert property (@(posedge dvtFlags) disable iff (pcFail)
    cmdValid |-> ##2 cmdDone)
    else $error("cmdDone missing two cycles after cmdValid");

  // One verdict only
  verdictExclusive: assert property (@(posedge dvtFlags) disable iff (pcFail)
    !(testPass && testFail))
    else $error("testPass and testFail high together");

  sleepAfterVerdict: assert property (@(posedge dvtFlags) disable iff (pcFail)
    ($rose(testPass || testFail) && !coreReset) |-> ##(`SLEEP_DELAY) $rose(coreReset))
    else $error("coreReset did not rise at the sleep delay");

  // First cycle out of reset
  tileHeldAfterReset: assert property (@(posedge dvtFlags)
    $fell(pcFail) |-> tileReset)
    else $error("tileReset low right after reset");

endmodule

bind coreSupervisor coreSupervisorProperties i_coreSupervisorProperties (
  .dvtFlags  (dvtFlags),
  .pcFail    (pcFail),
  .cmdValid  (cmdValid),
  .cmdDone   (cmdDone),
  .testPass  (testPass),
  .testFail  (testFail),
  .coreReset (coreReset),
  .tileReset (tileReset)
);

// File: sim/coreSupervisorTb.sv
`include "supervisor_consts.svh"

module coreSupervisorTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [`CORE_ID_WIDTH-1:0] tbCoreId = 2;
  localparam int cycleLimit = 3000;   // About twice what the five tests take

  typedef struct packed {
    supervisorPkg::patWord_u pat;
    logic tile;
    logic core;
    logic mon;
  } expect_s;

  logic dvtFlags;
  logic pcFail;
  logic patWrite;
  logic [`PAT_WIDTH-1:0] patIn;
  logic cmdValid;
  supervisorPkg::cmdOp_e cmdOp;
  logic [`PC_WIDTH-1:0] pcValue;
  logic pcValid;
  logic programLoaded;
  logic [`PC_WIDTH-1:0] passAddr;
  logic [`PC_WIDTH-1:0] failAddr;
  logic [`PC_WIDTH-1:0] hangAddr;
  logic addrValid;
  logic tileReset;
  logic coreReset;
  logic monitorEnable;
  logic testPass;
  logic testFail;
  logic [`PAT_WIDTH-1:0] patOut;
  logic cmdDone;

  integer seed = 62527;
  int cycles = 0;
  int errors = 0;
  int checks = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int errorsAtStart = 0;
  expect_s model;
  logic modelPass;
  logic modelFail;
  expect_s pending[$];

  coreSupervisor #(.myCoreId(tbCoreId)) i_coreSupervisor (.*);

  always #50 dvtFlags = ~dvtFlags;   // 100 ns period

  // --------------------------------------------------------------------------
  // Timeout and reference model
  // --------------------------------------------------------------------------

  always @(posedge dvtFlags) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("Run stopped: cycle limit of %0d reached", cycleLimit);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic expect_s refStep(input supervisorPkg::cmdOp_e op, input expect_s cur,
                                      input logic loaded, input logic pass, input logic fail);
    expect_s nxt;
    logic hit;
    nxt = cur;
    hit = (cur.pat.target.coreId == tbCoreId);   // Target from the pattern
    case (op)
      supervisorPkg::opForceTileReset:     if (hit) nxt.tile = 1'b1;
      supervisorPkg::opReleaseTileReset:   if (hit) nxt.tile = 1'b0;
      supervisorPkg::opForceCoreReset:     if (hit) nxt.core = 1'b1;
      supervisorPkg::opReleaseCoreReset:   if (hit) nxt.core = 1'b0;
      supervisorPkg::opEnableMonitor:      if (hit) nxt.mon = 1'b1;
      supervisorPkg::opGetCoreResetStatus: nxt.pat.raw[0] = cur.core;
      supervisorPkg::opGetProgramLoaded:   nxt.pat.raw[0] = loaded;
      supervisorPkg::opGetPassFailStatus: begin
        nxt.pat.raw = '0;   // Whole word replaced by the verdict
        nxt.pat.verdict.fail = fail;
        nxt.pat.verdict.pass = pass;
      end
      default: ;
    endcase
    return nxt;
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks and comparing process
  // --------------------------------------------------------------------------

  task automatic checkPat(input string name, input supervisorPkg::patWord_u got,
                          input supervisorPkg::patWord_u exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got.raw, exp.raw);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  always @(negedge dvtFlags) begin
    expect_s exp;
    if (!pcFail && cmdDone) begin
      if (pending.size() == 0) begin
        errors++;
        $display("Error at %0t: cmdDone pulsed with no command outstanding", $time);
      end else begin
        exp = pending.pop_front();
        checkPat("patOut", patOut, exp.pat);
        checkBit("tileReset", tileReset, exp.tile);
        checkBit("coreReset", coreReset, exp.core);
        checkBit("monitorEnable", monitorEnable, exp.mon);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------------------------------

  task automatic applyReset();
    @(posedge dvtFlags);
    #1 pcFail = 1'b1;
    repeat (10) @(posedge dvtFlags);
    #1 pcFail = 1'b0;
    pending.delete();
    model = '{pat: '0, tile: 1'b1, core: 1'b0, mon: 1'b0};
    modelPass = 1'b0;
    modelFail = 1'b0;
  endtask

  task automatic writePattern(input logic [`PAT_WIDTH-1:0] value);
    @(posedge dvtFlags);
    #1 patWrite = 1'b1;
    patIn = value;
    model.pat.raw = value;
    @(posedge dvtFlags);
    #1 patWrite = 1'b0;
  endtask

  task automatic issueCmd(input supervisorPkg::cmdOp_e op);
    int waited;
    @(posedge dvtFlags);
    #1 cmdValid = 1'b1;
    cmdOp = op;
    model = refStep(op, model, programLoaded, modelPass, modelFail);
    pending.push_back(model);
    @(posedge dvtFlags);
    #1 cmdValid = 1'b0;
    cmdOp = supervisorPkg::opNone;
    waited = 0;
    while (pending.size() != 0 && waited < 10) begin
      @(negedge dvtFlags);
      waited++;
    end
    #1;
    if (pending.size() != 0) begin
      errors++;
      pending.delete();
      $display("Error at %0t: cmdDone never came for opcode %0d", $time, op);
    end
  endtask

  task automatic setTable(input logic valid);
    passAddr = 64'h1000;
    failAddr = 64'h2000;
    hangAddr = 64'h3000;
    addrValid = valid;
  endtask

  task automatic drivePc(input logic [`PC_WIDTH-1:0] pc, input int count);
    repeat (count) begin
      @(posedge dvtFlags);
      #1 pcValue = pc;
      pcValid = 1'b1;
    end
    @(posedge dvtFlags);
    #1 pcValid = 1'b0;
  endtask

  task automatic driveRandomPcs(input int count);
    logic [`PC_WIDTH-1:0] pc;
    repeat (count) begin
      pc = {$random(seed), $random(seed)};
      pc[63] = 1'b1;   // Keeps it off every table entry
      drivePc(pc, 1);
    end
  endtask

  task automatic waitVerdict();
    int waited;
    waited = 0;
    while (!(testPass || testFail) && waited < 10) begin
      @(negedge dvtFlags);
      waited++;
    end
    if (!(testPass || testFail)) begin
      errors++;
      $display("Error at %0t: no verdict after the deciding PC", $time);
    end
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    if (errors != errorsAtStart) begin
      testsFailed++;
      $display("Test %s: FAIL (%0d errors)", name, errors - errorsAtStart);
    end else begin
      $display("Test %s: ok", name);
    end
    errorsAtStart = errors;
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  initial begin
    int n;
    dvtFlags = 1'b0;
    pcFail = 1'b1;
    patWrite = 1'b0;
    patIn = '0;
    cmdValid = 1'b0;
    cmdOp = supervisorPkg::opNone;
    pcValue = '0;
    pcValid = 1'b0;
    programLoaded = 1'b1;
    setTable(1'b1);

    applyReset();
    @(negedge dvtFlags);
    checkBit("tileReset", tileReset, 1'b1);
    checkBit("coreReset", coreReset, 1'b0);
    checkBit("monitorEnable", monitorEnable, 1'b0);
    checkBit("testPass", testPass, 1'b0);
    checkBit("testFail", testFail, 1'b0);
    checkBit("cmdDone", cmdDone, 1'b0);
    checkPat("patOut", patOut, '0);
    finishTest("reset values");

    writePattern(8'h02);
    issueCmd(supervisorPkg::opForceTileReset);
    issueCmd(supervisorPkg::opReleaseTileReset);
    issueCmd(supervisorPkg::opForceCoreReset);
    issueCmd(supervisorPkg::opReleaseCoreReset);
    issueCmd(supervisorPkg::opEnableMonitor);
    writePattern(8'h05);   // Other core
    issueCmd(supervisorPkg::opForceTileReset);
    issueCmd(supervisorPkg::opForceCoreReset);
    finishTest("targeted commands");

    writePattern(8'h02);
    issueCmd(supervisorPkg::opGetProgramLoaded);
    @(posedge dvtFlags);
    #1 programLoaded = 1'b0;   // Program gone, answer bit drops
    issueCmd(supervisorPkg::opGetProgramLoaded);
    writePattern(8'h02);
    issueCmd(supervisorPkg::opForceCoreReset);
    issueCmd(supervisorPkg::opGetCoreResetStatus);
    writePattern(8'h02);
    issueCmd(supervisorPkg::opReleaseCoreReset);
    issueCmd(supervisorPkg::opGetCoreResetStatus);
    issueCmd(supervisorPkg::opGetPassFailStatus);
    finishTest("status queries");

    applyReset();
    driveRandomPcs(20);
    drivePc(passAddr, 1);
    waitVerdict();
    modelPass = 1'b1;
    checkBit("testPass", testPass, 1'b1);
    checkBit("testFail", testFail, 1'b0);
    n = 0;
    while (!coreReset && n < 40) begin
      @(negedge dvtFlags);
      n++;
    end
    checkCount("coreReset delay", n, `SLEEP_DELAY);
    model.core = 1'b1;
    issueCmd(supervisorPkg::opGetPassFailStatus);
    applyReset();
    driveRandomPcs(20);
    drivePc(failAddr, 1);
    waitVerdict();
    modelFail = 1'b1;
    checkBit("testPass", testPass, 1'b0);
    checkBit("testFail", testFail, 1'b1);
    issueCmd(supervisorPkg::opGetPassFailStatus);   // Done well before sleep
    finishTest("address verdicts");

    applyReset();
    drivePc(64'h8000_0000_0000_0040, `STUCK_LIMIT);
    repeat (2) @(negedge dvtFlags);
    checkBit("testFail", testFail, 1'b0);
    drivePc(64'h8000_0000_0000_0040, 1);   // Sample number 501
    repeat (2) @(negedge dvtFlags);
    checkBit("testFail", testFail, 1'b1);
    applyReset();
    issueCmd(supervisorPkg::opDisableStuckCheck);
    drivePc(64'h8000_0000_0000_0040, `STUCK_LIMIT + 5);
    repeat (2) @(negedge dvtFlags);
    checkBit("testPass", testPass, 1'b0);
    checkBit("testFail", testFail, 1'b0);
    applyReset();
    setTable(1'b0);
    drivePc(64'h8000_0000_0000_0080, 1);
    repeat (2) @(negedge dvtFlags);
    checkBit("testFail", testFail, 1'b1);
    finishTest("stuck and table checks");

    $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
             testsRun, testsFailed, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+common
common/supervisorPkg.sv
logic/commandDecoder.sv
monitor/pcProgressMonitor.sv
logic/resetStatusUnit.sv
logic/coreSupervisor.sv
sim/coreSupervisor_properties.sv
sim/coreSupervisorTb.sv

// File: run.sh
#!/bin/sh
# Build and run the coreSupervisor testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module coreSupervisorTb -o simv > build.log 2>&1 \
  && ./obj_dir/simv > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "^Testbench passed$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
